/* sim/rdma_tx_stim.txt */
# R region count opcode qpn vaddr len (hex fields), M ready mode 0 high 1 low 2 random
# D wait for empty path, F check accepted counts under stall, A check round-robin order
M 0
R 0 1 04 001 000000001000 0000040
R 1 1 06 102 0000a0002000 0000100
R 2 1 0a 203 7fff00000000 fffffff
R 3 1 11 3ff ffffffffe000 0000001
D
R 0 6 04 010 000010000000 0000200
R 1 3 06 120 000020000000 0001000
R 2 8 0a 230 000030000000 0000080
R 3 2 1f 340 000040000000 0000010
D
M 1
R 0 7 0c 050 100000000000 0000400
R 1 7 0d 150 200000000000 0000800
R 2 7 0e 250 300000000000 0000c00
R 3 7 0f 350 400000000000 0001000
F
M 0
A
D
M 2
R 0 9 01 060 500000000000 0000020
R 1 9 02 160 600000000000 0000040
R 2 9 03 260 700000000000 0000060
R 3 9 05 360 800000000000 0000080
D

/* flist.f */
+incdir+hdl
hdl/rdma_tx_pkg.sv
hdl/rdma_meta_queue.sv
hdl/rdma_meta_tx_arbiter.sv
hdl/rdma_psn_stamp.sv
hdl/rdma_tx_meta_top.sv
sim/tb_clk_gen.sv
sim/rdma_tx_asserts.sv
sim/rdma_tx_tb.sv

/* Bender.yml */
package:
  name: rdma_tx_meta

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rdma_tx_pkg.sv
      - hdl/rdma_meta_queue.sv
      - hdl/rdma_meta_tx_arbiter.sv
      - hdl/rdma_psn_stamp.sv
      - hdl/rdma_tx_meta_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/tb_clk_gen.sv
      - sim/rdma_tx_asserts.sv
      - sim/rdma_tx_tb.sv

/* sim/rdma_tx_tb.sv */
// runs sim/rdma_tx_stim.txt from the project root; expects an empty path after each D.
// F assumes empty queues and a stalled output with DEPTH+1 or more requests per region.
`timescale 1ns/1ps
`include "rdma_tx_defs.svh"

module rdma_tx_tb;

  import rdma_tx_pkg::*;

  localparam int N = `RDMA_N_REGIONS;
  localparam int DEPTH = `RDMA_QUEUE_DEPTH;

  logic                  aclk;
  logic                  aresetn;
  logic      [N-1:0]     s_req_valid;
  logic      [N-1:0]     s_req_ready;
  rdma_req_t [N-1:0]     s_req;
  logic                  m_meta_valid;
  logic                  m_meta_ready;
  rdma_meta_t            m_meta;

  rdma_req_t pend [N][$];  // waiting to be driven.
  rdma_req_t exp_q [N][$]; // expected output order per region.
  psn_t      model_psn [N];
  int        accepted [N]; // input handshakes since last drain.
  int        cycle = 0;
  int        last_acc = 0;
  int        limit = 0;
  int        ready_mode = 0; // 0 high, 1 low, 2 random.
  int        err_val = 0;
  int        err_other = 0;
  int        seed = 32'h735bbae2;
  logic      rr_arm = 1'b0;
  logic      rr_have = 1'b0;
  vfid_t     rr_last;

  // parsed records.
  string     rec_kind [$];
  logic [63:0] rec_f [$][6];

  tb_clk_gen clk_gen_i (.aclk(aclk), .aresetn(aresetn));

  rdma_tx_meta_top dut_i (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .s_req_valid  (s_req_valid),
    .s_req_ready  (s_req_ready),
    .s_req        (s_req),
    .m_meta_valid (m_meta_valid),
    .m_meta_ready (m_meta_ready),
    .m_meta       (m_meta)
  );

  bind rdma_tx_meta_top rdma_tx_asserts asserts_i (
    .aclk (aclk), .aresetn (aresetn), .s_req_valid (s_req_valid),
    .s_req_ready (s_req_ready), .m_meta_valid (m_meta_valid),
    .m_meta_ready (m_meta_ready), .m_meta (m_meta)
  );

  task automatic compare_req(string name, rdma_req_t exp, rdma_req_t act);
    if (exp !== act) begin
      $display("ERR t=%0t %s exp=%h act=%h", $time, name, exp, act);
      err_val++;
    end
  endtask

  task automatic compare_vfid(string name, vfid_t exp, vfid_t act);
    if (exp !== act) begin
      $display("ERR t=%0t %s exp=%h act=%h", $time, name, exp, act);
      err_val++;
    end
  endtask

  task automatic compare_psn(string name, psn_t exp, psn_t act);
    if (exp !== act) begin
      $display("ERR t=%0t %s exp=%h act=%h", $time, name, exp, act);
      err_val++;
    end
  endtask

  // i-th request of a burst: qpn steps by one, vaddr by 4 KiB.
  function automatic rdma_req_t burst_req(logic [63:0] f[6], int i);
    rdma_req_t r;
    r.opcode = opcode_t'(f[2]);
    r.qpn    = qpn_t'(f[3] + i);
    r.vaddr  = vaddr_t'(f[4] + (64'(i) << 12));
    r.len    = len_t'(f[5]);
    return r;
  endfunction

  // all DUT inputs change here, on the rising edge.
  always @(posedge aclk) begin
    cycle <= cycle + 1;
    if (!aresetn) begin
      s_req_valid <= '0;
    end else begin
      for (int r = 0; r < N; r++) begin
        if (s_req_valid[r] && s_req_ready[r]) begin
          accepted[r]++;
          last_acc = cycle;
        end
        if (!s_req_valid[r] || s_req_ready[r]) begin
          if (pend[r].size() > 0) begin
            s_req_valid[r] <= 1'b1;
            s_req[r]       <= pend[r].pop_front();
          end else begin
            s_req_valid[r] <= 1'b0;
          end
        end
      end
      case (ready_mode)
        0: m_meta_ready <= 1'b1;
        1: m_meta_ready <= 1'b0;
        default: m_meta_ready <= 1'($random(seed));
      endcase
    end
  end

  // output monitor against the per-region model.
  always @(posedge aclk) begin
    rdma_req_t exp;
    vfid_t     v;
    if (aresetn && m_meta_valid && m_meta_ready) begin
      v = m_meta.vfid;
      if (exp_q[v].size() == 0) begin
        $display("output at t=%0t from region %0d which has no request left", $time, v);
        err_other++;
      end else begin
        exp = exp_q[v].pop_front();
        compare_req("m_meta.req", exp, m_meta.req);
        compare_psn("m_meta.psn", model_psn[v], m_meta.psn);
        model_psn[v]++;
      end
      if (rr_arm && rr_have) compare_vfid("m_meta.vfid", vfid_t'((rr_last + 1) % N), v);
      rr_last = v;
      rr_have = rr_arm;
    end
  end

  // run limit.
  always @(posedge aclk) begin
    if (limit != 0 && cycle >= limit) begin
      $display("timeout after %0d cycles, the path did not drain", cycle);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  function automatic logic idle_path();
    logic idle;
    idle = !m_meta_valid && (s_req_valid == '0);
    for (int r = 0; r < N; r++) begin
      if (pend[r].size() != 0 || exp_q[r].size() != 0) idle = 1'b0;
    end
    return idle;
  endfunction

  initial begin
    int    fd;
    int    code;
    int    n_req;
    int    n_big;
    string tok;
    string line;
    logic [63:0] f [6];
    s_req_valid  = '0;
    s_req        = '0;
    m_meta_ready = 1'b1;
    n_req = 0;
    for (int r = 0; r < N; r++) begin
      model_psn[r] = '0;
      accepted[r]  = 0;
    end
    fd = $fopen("sim/rdma_tx_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file");
      $display("STATUS: FAIL");
      $finish;
    end else begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        f = '{default: '0};
        if (tok == "#") begin
          code = $fgets(line, fd); // comment line.
        end else begin
          if (tok == "R") begin
            code = $fscanf(fd, "%d %d %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
            if (code != 6) begin
              $display("request record %0d in the stimulus file is incomplete", rec_kind.size());
              err_other++;
            end
            n_req += int'(f[1]);
          end else if (tok == "M") begin
            code = $fscanf(fd, "%d", f[0]);
            if (code != 1) begin
              $display("mode record %0d in the stimulus file has no mode", rec_kind.size());
              err_other++;
            end
          end
          rec_kind.push_back(tok);
          rec_f.push_back(f);
        end
      end
      $fclose(fd);
      limit = n_req * (N + 4) + 200;
      wait (aresetn === 1'b1);
      @(negedge aclk);
      if (m_meta_valid !== 1'b0) begin
        $display("ERR t=%0t m_meta_valid exp=0 act=%b", $time, m_meta_valid);
        err_val++;
      end
      if (s_req_ready !== '1) begin
        $display("ERR t=%0t s_req_ready exp=%h act=%h", $time, {N{1'b1}}, s_req_ready);
        err_val++;
      end
      foreach (rec_kind[k]) begin
        f = rec_f[k];
        case (rec_kind[k])
          "R": begin
            for (int i = 0; i < int'(f[1]); i++) begin
              pend[f[0]].push_back(burst_req(f, i));
              exp_q[f[0]].push_back(burst_req(f, i));
            end
          end
          "M": ready_mode = int'(f[0]);
          "A": rr_arm = 1'b1;
          "D": begin
            do @(negedge aclk); while (!idle_path());
            rr_arm  = 1'b0;
            rr_have = 1'b0;
            for (int r = 0; r < N; r++) accepted[r] = 0;
          end
          "F": begin
            last_acc = cycle;
            while (cycle - last_acc < 8) @(negedge aclk); // no input handshake for a while.
            n_big = 0;
            for (int r = 0; r < N; r++) begin
              if (accepted[r] == DEPTH + 1) n_big++;
              else if (accepted[r] != DEPTH) begin
                $display("region %0d took %0d requests while stalled", r, accepted[r]);
                err_other++;
              end
            end
            if (n_big != 1) begin
              $display("%0d regions took an extra request while stalled, one expected", n_big);
              err_other++;
            end
          end
          default: begin
            $display("unknown record %s in the stimulus file", rec_kind[k]);
            err_other++;
          end
        endcase
      end
      for (int r = 0; r < N; r++) begin
        if (exp_q[r].size() != 0) begin
          $display("region %0d still expects %0d outputs", r, exp_q[r].size());
          err_other++;
        end
      end
      $display("errors: value %0d, other %0d, assertion %0d", err_val, err_other,
               dut_i.asserts_i.fail_cnt);
      if (err_val == 0 && err_other == 0 && dut_i.asserts_i.fail_cnt == 0) begin
        $display("STATUS: PASS");
      end else begin
        $display("STATUS: FAIL");
      end
      $finish;
    end
  end

endmodule

/* sim/rdma_tx_asserts.sv */
// handshake checks on the top level; bound into rdma_tx_meta_top.
`timescale 1ns/1ps
`include "rdma_tx_defs.svh"

module rdma_tx_asserts (
  input logic                           aclk,
  input logic                           aresetn,
  input logic [`RDMA_N_REGIONS-1:0]     s_req_valid,
  input logic [`RDMA_N_REGIONS-1:0]     s_req_ready,
  input logic                           m_meta_valid,
  input logic                           m_meta_ready,
  input rdma_tx_pkg::rdma_meta_t        m_meta
);

  import rdma_tx_pkg::*;

  int fail_cnt = 0; // assertions that fired.

  // stalled output keeps valid and payload.
  out_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    m_meta_valid && !m_meta_ready |=> m_meta_valid && $stable(m_meta))
    else begin
      $error("m_meta changed while stalled");
      fail_cnt++;
    end

  // register is empty right after reset.
  out_reset: assert property (@(posedge aclk) !aresetn |=> !m_meta_valid)
    else begin
      $error("m_meta_valid high after reset");
      fail_cnt++;
    end

  for (genvar i = 0; i < `RDMA_N_REGIONS; i++) begin : g_in
    in_stable: assert property (@(posedge aclk) disable iff (!aresetn)
      s_req_valid[i] && !s_req_ready[i] |=> s_req_valid[i])
      else begin
        $error("s_req_valid dropped while stalled");
        fail_cnt++;
      end
  end

endmodule

/* sim/tb_clk_gen.sv */
// testbench clock, 10 ns period; aresetn low for the first 2 rising edges.
`timescale 1ns/1ps

module tb_clk_gen (
  output logic aclk,
  output logic aresetn
);

  initial begin
    aclk    = 1'b0;
    aresetn = 1'b0;
    forever #5 aclk = ~aclk; // 100 MHz.
  end

  initial begin
    repeat (2) @(posedge aclk);
    aresetn <= 1'b1; // released on the rising edge.
  end

endmodule

/* hdl/rdma_tx_meta_top.sv */
// tx request-metadata path: region queues, arbiter, then psn stamping.
`timescale 1ns/1ps
`include "rdma_tx_defs.svh"

module rdma_tx_meta_top (
  input  logic                                         aclk,
  input  logic                                         aresetn,
  input  logic                   [`RDMA_N_REGIONS-1:0] s_req_valid,
  output logic                   [`RDMA_N_REGIONS-1:0] s_req_ready,
  input  rdma_tx_pkg::rdma_req_t [`RDMA_N_REGIONS-1:0] s_req,
  output logic                                         m_meta_valid,
  input  logic                                         m_meta_ready,
  output rdma_tx_pkg::rdma_meta_t                      m_meta
);

  import rdma_tx_pkg::*;

  logic      arb_valid; // arbiter to stamper.
  logic      arb_ready;
  rdma_req_t arb_req;
  vfid_t     arb_vfid;  // winning region.

  rdma_meta_tx_arbiter arbiter_i (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (s_req_valid),
    .s_ready (s_req_ready),
    .s_req   (s_req),
    .m_valid (arb_valid),
    .m_ready (arb_ready),
    .m_req   (arb_req),
    .vfid    (arb_vfid)
  );

  rdma_psn_stamp stamp_i (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (arb_valid),
    .s_ready (arb_ready),
    .s_req   (arb_req),
    .s_vfid  (arb_vfid),
    .m_valid (m_meta_valid),
    .m_ready (m_meta_ready),
    .m_meta  (m_meta)
  );

endmodule

/* hdl/rdma_psn_stamp.sv */
// single output register that attaches vfid and a per-region psn.
// psn counters roll over at full width and are not tied to any connection.
`timescale 1ns/1ps
`include "rdma_tx_defs.svh"

module rdma_psn_stamp (
  input  logic                    aclk,
  input  logic                    aresetn,
  input  logic                    s_valid,
  output logic                    s_ready,
  input  rdma_tx_pkg::rdma_req_t  s_req,
  input  rdma_tx_pkg::vfid_t      s_vfid,
  output logic                    m_valid,
  input  logic                    m_ready,
  output rdma_tx_pkg::rdma_meta_t m_meta
);

  import rdma_tx_pkg::*;

  localparam int N_REGIONS = `RDMA_N_REGIONS;

  psn_t       psn_cnt [N_REGIONS]; // next psn per region.
  logic       valid_q;             // output register holds a word.
  rdma_meta_t meta_q;              // output payload.
  logic       accept;              // input handshake.

  assign s_ready = ~valid_q | m_ready; // free now or emptied this edge.
  assign accept  = s_valid & s_ready;
  assign m_valid = valid_q;
  assign m_meta  = meta_q;

  // valid flag and counters.
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      valid_q <= 1'b0;
      for (int i = 0; i < N_REGIONS; i++) begin
        psn_cnt[i] <= '0;
      end
    end else begin
      if (accept) begin
        valid_q         <= 1'b1;
        psn_cnt[s_vfid] <= psn_cnt[s_vfid] + 1'b1; // plain roll-over.
      end else if (m_ready) begin
        valid_q <= 1'b0; // drained with nothing behind.
      end
    end
  end

  // payload capture, held under back-pressure.
  always_ff @(posedge aclk) begin
    if (accept) begin
      meta_q.req  <= s_req;
      meta_q.vfid <= s_vfid;
      meta_q.psn  <= psn_cnt[s_vfid]; // psn before the increment.
    end
  end

endmodule

/* hdl/rdma_meta_tx_arbiter.sv */
// round-robin arbitration over the per-region queues; vfid is the winning region.
// pointer moves by one on every output handshake, whichever region won.
`timescale 1ns/1ps
`include "rdma_tx_defs.svh"

module rdma_meta_tx_arbiter (
  input  logic                                         aclk,
  input  logic                                         aresetn,
  input  logic                   [`RDMA_N_REGIONS-1:0] s_valid,
  output logic                   [`RDMA_N_REGIONS-1:0] s_ready,
  input  rdma_tx_pkg::rdma_req_t [`RDMA_N_REGIONS-1:0] s_req,
  output logic                                         m_valid,
  input  logic                                         m_ready,
  output rdma_tx_pkg::rdma_req_t                       m_req,
  output rdma_tx_pkg::vfid_t                           vfid
);

  import rdma_tx_pkg::*;

  localparam int N_REGIONS = `RDMA_N_REGIONS;

  logic      [N_REGIONS-1:0] q_valid; // queue heads present.
  logic      [N_REGIONS-1:0] q_ready; // pop strobe, winner only.
  rdma_req_t [N_REGIONS-1:0] q_req;   // queue heads.

  vfid_t rr_ptr; // region searched first.
  vfid_t sel;    // granted region.
  logic  found;  // some head is valid.

  // one queue per region.
  for (genvar i = 0; i < N_REGIONS; i++) begin : g_queue
    rdma_meta_queue #(
      .DEPTH (`RDMA_QUEUE_DEPTH)
    ) queue_i (
      .aclk    (aclk),
      .aresetn (aresetn),
      .s_valid (s_valid[i]),
      .s_ready (s_ready[i]),
      .s_data  (s_req[i]),
      .m_valid (q_valid[i]),
      .m_ready (q_ready[i]),
      .m_data  (q_req[i])
    );
  end

  // search upward from the pointer, wrapping.
  always_comb begin
    int idx;
    found = 1'b0;
    sel   = rr_ptr;
    for (int i = 0; i < N_REGIONS; i++) begin
      idx = (int'(rr_ptr) + i) % N_REGIONS;
      if (!found && q_valid[idx]) begin
        found = 1'b1;       // first hit wins.
        sel   = vfid_t'(idx);
      end
    end
  end

  always_comb begin
    q_ready      = '0;
    q_ready[sel] = m_ready & found; // only the winning queue pops.
  end

  assign m_valid = found;
  assign m_req   = q_req[sel]; // head of the granted queue.
  assign vfid    = sel;

  // pointer steps on each granted handshake.
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rr_ptr <= '0;
    end else if (m_valid && m_ready) begin
      if (rr_ptr == vfid_t'(N_REGIONS - 1)) rr_ptr <= '0; // wrap to region 0.
      else rr_ptr <= rr_ptr + 1'b1;
    end
  end

endmodule

/* hdl/rdma_meta_queue.sv */
// small per-region descriptor fifo; a written word is visible one cycle later.
// s_ready is a registered full flag and only drops with DEPTH entries held.
`timescale 1ns/1ps
`include "rdma_tx_defs.svh"

module rdma_meta_queue #(
  parameter int DEPTH = `RDMA_QUEUE_DEPTH
) (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  s_valid,
  output logic                  s_ready,
  input  rdma_tx_pkg::rdma_req_t s_data,
  output logic                  m_valid,
  input  logic                  m_ready,
  output rdma_tx_pkg::rdma_req_t m_data
);

  import rdma_tx_pkg::*;

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  rdma_req_t           mem [DEPTH]; // storage, no reset needed.
  logic [PTR_BITS-1:0] wr_ptr;      // next slot to write.
  logic [PTR_BITS-1:0] rd_ptr;      // current head slot.
  logic [CNT_BITS-1:0] count;       // entries held.
  logic [CNT_BITS-1:0] count_nxt;   // occupancy after this edge.
  logic                full_q;      // registered full flag.
  logic                push;        // input handshake.
  logic                pop;         // output handshake.

  assign s_ready = ~full_q;
  assign m_valid = (count != '0);     // head is valid once written.
  assign m_data  = mem[rd_ptr];       // fall-through read of the head.

  assign push = s_valid & s_ready;
  assign pop  = m_valid & m_ready;

  always_comb begin
    count_nxt = count;
    if (push && !pop) count_nxt = count + 1'b1;
    else if (pop && !push) count_nxt = count - 1'b1;
  end

  // pointers and flags.
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full_q <= 1'b0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // wraps at depth.
      if (pop)  rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count  <= count_nxt;
      full_q <= (count_nxt == CNT_BITS'(DEPTH)); // full seen one edge after the last write.
    end
  end

  // payload write.
  always_ff @(posedge aclk) begin
    if (push) mem[wr_ptr] <= s_data;
  end

endmodule

/* hdl/rdma_tx_pkg.sv */
// types shared by the tx request-metadata path.
// field widths come from rdma_tx_defs.svh.
`include "rdma_tx_defs.svh"

package rdma_tx_pkg;

  // plain field vectors.
  typedef logic [`RDMA_VFID_BITS-1:0]   vfid_t;   // region index.
  typedef logic [`RDMA_QPN_BITS-1:0]    qpn_t;    // queue pair number.
  typedef logic [`RDMA_VADDR_BITS-1:0]  vaddr_t;  // virtual address.
  typedef logic [`RDMA_LEN_BITS-1:0]    len_t;    // transfer length.
  typedef logic [`RDMA_OPCODE_BITS-1:0] opcode_t; // rdma opcode.
  typedef logic [`RDMA_PSN_BITS-1:0]    psn_t;    // packet sequence number.

  // one descriptor as a region issues it, 91 bits.
  typedef struct packed {
    opcode_t opcode; // operation.
    qpn_t    qpn;    // target queue pair.
    vaddr_t  vaddr;  // local buffer address.
    len_t    len;    // bytes to move.
  } rdma_req_t;

  // descriptor as it leaves toward the network stack.
  typedef struct packed {
    rdma_req_t req;  // request as issued.
    vfid_t     vfid; // issuing region.
    psn_t      psn;  // per-region sequence number.
  } rdma_meta_t;

endpackage

/* hdl/rdma_tx_defs.svh */
// sizes for the tx request-metadata path; RDMA_VFID_BITS must cover RDMA_N_REGIONS.
// RDMA_N_REGIONS is expected to be at least 2.
`ifndef RDMA_TX_DEFS_SVH
`define RDMA_TX_DEFS_SVH

// region setup.
`define RDMA_N_REGIONS   4  // number of user regions.
`define RDMA_VFID_BITS   2  // width of a region index.
`define RDMA_QUEUE_DEPTH 4  // entries per region queue.

// descriptor fields.
`define RDMA_QPN_BITS    10 // queue pair number.
`define RDMA_VADDR_BITS  48 // virtual address.
`define RDMA_LEN_BITS    28 // transfer length in bytes.
`define RDMA_OPCODE_BITS 5  // rdma opcode.

// sequence numbers.
`define RDMA_PSN_BITS    24 // packet sequence number, rolls over.

`endif
